// File: design/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // Datapath and register file sizing
    localparam int dataW = 32;
    localparam int regIdW = 5;
    localparam int regCount = 1 << regIdW;
    localparam int immW = 16;

    // First fetch address out of reset
    localparam logic [dataW-1:0] resetPc = 32'h0040_0000;

    // Hardwired zero register
    localparam logic [regIdW-1:0] regZero = '0;

    // Primary opcodes, inst[31:26]
    typedef enum logic [5:0] {
        rType = 6'h00,
        beq   = 6'h04,
        bne   = 6'h05,
        addi  = 6'h08,
        addiu = 6'h09,
        slti  = 6'h0A,
        andi  = 6'h0C,
        ori   = 6'h0D,
        lui   = 6'h0F,
        lw    = 6'h23,
        sw    = 6'h2B
    } opcodeE;

    // R-type funct field, inst[5:0]
    typedef enum logic [5:0] {
        fnAdd  = 6'h20,
        fnAddu = 6'h21,
        fnSub  = 6'h22,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnNor  = 6'h27,
        fnSlt  = 6'h2A
    } functE;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluNor = 4'd5,
        aluSlt = 4'd6,
        aluLui = 4'd7
    } aluOpE;

    // Operand source seen by the EX stage
    typedef enum logic [1:0] {
        fwdNone  = 2'd0,
        fwdExMem = 2'd1,
        fwdMemWb = 2'd2
    } fwdSelE;

endpackage

`default_nettype wire

// File: design/instDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instDecoder (
    input  logic [cpuPkg::dataW-1:0] inst,
    output logic                     regDst,
    output logic                     regWrite,
    output logic                     aluSrcImm,
    output logic                     memRead,
    output logic                     memWrite,
    output logic                     memToReg,
    output logic                     branch,
    output logic                     branchEq,
    output cpuPkg::aluOpE            aluOp,
    output logic                     signedOp
);

    cpuPkg::opcodeE opcode;
    cpuPkg::functE  funct;
    logic           functKnown;

    assign opcode = cpuPkg::opcodeE'(inst[31:26]);
    assign funct  = cpuPkg::functE'(inst[5:0]);

    // Main control, by instruction class
    always_comb begin
        regDst    = 1'b0;
        regWrite  = 1'b0;
        aluSrcImm = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        branch    = 1'b0;
        branchEq  = 1'b0;
        case (opcode)
            cpuPkg::rType: begin
                regDst   = 1'b1;
                // Unsupported funct retires as a no-op
                regWrite = functKnown;
            end
            cpuPkg::lw: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                memToReg  = 1'b1;
            end
            cpuPkg::sw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            cpuPkg::beq, cpuPkg::bne: begin
                branch   = 1'b1;
                branchEq = (opcode == cpuPkg::beq);
            end
            cpuPkg::addi, cpuPkg::addiu, cpuPkg::andi,
            cpuPkg::ori, cpuPkg::slti, cpuPkg::lui: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            default: begin
                regWrite = 1'b0;
            end
        endcase
    end

    // ALU operation from funct or opcode
    always_comb begin
        aluOp      = cpuPkg::aluAdd;
        signedOp   = 1'b0;
        functKnown = 1'b1;
        case (opcode)
            cpuPkg::rType: begin
                case (funct)
                    cpuPkg::fnAdd: signedOp = 1'b1;
                    cpuPkg::fnAddu: aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSub: begin
                        aluOp    = cpuPkg::aluSub;
                        signedOp = 1'b1;
                    end
                    cpuPkg::fnSubu: aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr: aluOp = cpuPkg::aluOr;
                    cpuPkg::fnXor: aluOp = cpuPkg::aluXor;
                    cpuPkg::fnNor: aluOp = cpuPkg::aluNor;
                    cpuPkg::fnSlt: begin
                        aluOp    = cpuPkg::aluSlt;
                        signedOp = 1'b1;
                    end
                    default: functKnown = 1'b0;
                endcase
            end
            // Branch compares by subtraction
            cpuPkg::beq, cpuPkg::bne: aluOp = cpuPkg::aluSub;
            cpuPkg::addi: signedOp = 1'b1;
            cpuPkg::andi: aluOp = cpuPkg::aluAnd;
            cpuPkg::ori: aluOp = cpuPkg::aluOr;
            cpuPkg::slti: begin
                aluOp    = cpuPkg::aluSlt;
                signedOp = 1'b1;
            end
            cpuPkg::lui: aluOp = cpuPkg::aluLui;
            default: aluOp = cpuPkg::aluAdd;
        endcase
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic                      iClk,
    input  logic                      iRst_n,
    input  logic [cpuPkg::regIdW-1:0] rdIdA,
    input  logic [cpuPkg::regIdW-1:0] rdIdB,
    output logic [cpuPkg::dataW-1:0]  rdDataA,
    output logic [cpuPkg::dataW-1:0]  rdDataB,
    input  logic [cpuPkg::regIdW-1:0] wrId,
    input  logic [cpuPkg::dataW-1:0]  wrData,
    input  logic                      wrEn
);

    logic [cpuPkg::dataW-1:0] regs [cpuPkg::regCount];
    logic                     wrLive;

    // Register zero never takes a write
    assign wrLive = wrEn && (wrId != cpuPkg::regZero);

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            for (int i = 0; i < cpuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrId] <= wrData;
        end
    end

    // Write-through so WB and ID can share a cycle
    assign rdDataA = (wrLive && wrId == rdIdA) ? wrData : regs[rdIdA];
    assign rdDataB = (wrLive && wrId == rdIdB) ? wrData : regs[rdIdB];

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic [cpuPkg::dataW-1:0] a,
    input  logic [cpuPkg::dataW-1:0] b,
    input  cpuPkg::aluOpE            op,
    input  logic                     signedOp,
    output logic [cpuPkg::dataW-1:0] result,
    output logic                     zero
);

    logic lessThan;

    // Only slt cares about signedness, overflow is ignored
    assign lessThan = signedOp ? ($signed(a) < $signed(b)) : (a < b);

    always_comb begin
        case (op)
            cpuPkg::aluAdd: result = a + b;
            cpuPkg::aluSub: result = a - b;
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr: result = a | b;
            cpuPkg::aluXor: result = a ^ b;
            cpuPkg::aluNor: result = ~(a | b);
            cpuPkg::aluSlt: result = {{(cpuPkg::dataW-1){1'b0}}, lessThan};
            // Immediate into the upper half
            cpuPkg::aluLui: begin
                result = {b[cpuPkg::immW-1:0], {(cpuPkg::dataW-cpuPkg::immW){1'b0}}};
            end
            default: result = a + b;
        endcase
    end

    // Equality test for beq/bne
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  logic [cpuPkg::regIdW-1:0] idRs,
    input  logic [cpuPkg::regIdW-1:0] idRt,
    input  logic [cpuPkg::regIdW-1:0] exRs,
    input  logic [cpuPkg::regIdW-1:0] exRt,
    input  logic [cpuPkg::regIdW-1:0] exMemWrId,
    input  logic [cpuPkg::regIdW-1:0] memWbWrId,
    input  logic                      exMemRead,
    input  logic                      exMemRegWrite,
    input  logic                      memWbRegWrite,
    input  logic                      branchTaken,
    output cpuPkg::fwdSelE            fwdA,
    output cpuPkg::fwdSelE            fwdB,
    output logic                      stallFront,
    output logic                      flushIfId,
    output logic                      flushIdEx
);

    logic loadUse;

    // Youngest producer first, never for register zero
    function automatic cpuPkg::fwdSelE pickSource(
        input logic [cpuPkg::regIdW-1:0] src,
        input logic [cpuPkg::regIdW-1:0] memId,
        input logic                      memWe,
        input logic [cpuPkg::regIdW-1:0] wbId,
        input logic                      wbWe
    );
        if (memWe && memId != cpuPkg::regZero && memId == src) begin
            return cpuPkg::fwdExMem;
        end
        if (wbWe && wbId != cpuPkg::regZero && wbId == src) begin
            return cpuPkg::fwdMemWb;
        end
        return cpuPkg::fwdNone;
    endfunction

    assign fwdA = pickSource(exRs, exMemWrId, exMemRegWrite, memWbWrId, memWbRegWrite);
    assign fwdB = pickSource(exRt, exMemWrId, exMemRegWrite, memWbWrId, memWbRegWrite);

    // Load in EX whose rt is read by the instruction in ID
    assign loadUse = exMemRead && (exRt != cpuPkg::regZero)
                     && (exRt == idRs || exRt == idRt);

    // A taken branch kills both shadow slots, overriding any stall
    assign flushIfId  = branchTaken;
    assign flushIdEx  = branchTaken || loadUse;
    assign stallFront = loadUse && !branchTaken;

endmodule

`default_nettype wire

// File: design/pipeCore.sv
`timescale 1ns/10ps
`default_nettype none

module pipeCore (
    input  logic                     iClk,
    input  logic                     iRst_n,
    output logic [cpuPkg::dataW-1:0] oInstAddr,
    input  logic [cpuPkg::dataW-1:0] iInst,
    output logic [cpuPkg::dataW-1:0] oMemAddr,
    output logic [cpuPkg::dataW-1:0] oMemWrData,
    output logic                     oMemWrite,
    output logic                     oMemRead,
    input  logic [cpuPkg::dataW-1:0] iMemRdData
);

    // Fetch
    logic [cpuPkg::dataW-1:0] pc, fetchPcPlus4;
    // IF/ID
    logic [cpuPkg::dataW-1:0] ifIdInst, ifIdPcPlus4;
    // Decode
    logic idRegDst, idRegWrite, idAluSrcImm, idMemRead, idMemWrite;
    logic idMemToReg, idBranch, idBranchEq, idSignedOp;
    cpuPkg::aluOpE idAluOp;
    logic [cpuPkg::dataW-1:0] idRsData, idRtData;
    // ID/EX
    logic idExRegDst, idExRegWrite, idExAluSrcImm, idExMemRead, idExMemWrite;
    logic idExMemToReg, idExBranch, idExBranchEq, idExSignedOp;
    cpuPkg::aluOpE idExAluOp;
    logic [cpuPkg::dataW-1:0] idExRsData, idExRtData, idExPcPlus4;
    logic [cpuPkg::regIdW-1:0] idExRs, idExRt, idExRd;
    logic [cpuPkg::immW-1:0] idExImm;
    // Execute
    cpuPkg::fwdSelE fwdA, fwdB;
    logic [cpuPkg::dataW-1:0] exRsVal, exRtVal, exImm, exAluB, exAluOut;
    logic [cpuPkg::dataW-1:0] branchTarget;
    logic [cpuPkg::regIdW-1:0] exWrId;
    logic exZero, branchTaken, stallFront, flushIfId, flushIdEx;
    // EX/MEM
    logic exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg;
    logic [cpuPkg::dataW-1:0] exMemAluOut, exMemStoreData;
    logic [cpuPkg::regIdW-1:0] exMemWrId;
    // MEM/WB
    logic memWbRegWrite;
    logic [cpuPkg::dataW-1:0] memWbData;
    logic [cpuPkg::regIdW-1:0] memWbWrId;

    function automatic logic [cpuPkg::dataW-1:0] fwdMux(
        input cpuPkg::fwdSelE           sel,
        input logic [cpuPkg::dataW-1:0] regVal,
        input logic [cpuPkg::dataW-1:0] memVal,
        input logic [cpuPkg::dataW-1:0] wbVal
    );
        case (sel)
            cpuPkg::fwdExMem: return memVal;
            cpuPkg::fwdMemWb: return wbVal;
            default: return regVal;
        endcase
    endfunction

    // Branch target goes out in the resolving cycle and is fetched again from PC
    assign oInstAddr    = branchTaken ? branchTarget : pc;
    assign fetchPcPlus4 = oInstAddr + 32'd4;

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            pc       <= cpuPkg::resetPc;
            ifIdInst <= '0;
        end else begin
            if (branchTaken) begin
                pc <= branchTarget;
            end else if (!stallFront) begin
                pc <= fetchPcPlus4;
            end
            if (flushIfId) begin
                ifIdInst <= '0;
            end else if (!stallFront) begin
                ifIdInst <= iInst;
            end
        end
    end

    always_ff @(posedge iClk) begin
        if (!stallFront) begin
            ifIdPcPlus4 <= fetchPcPlus4;
        end
    end

    instDecoder i_instDecoder (
        .inst      (ifIdInst),
        .regDst    (idRegDst),
        .regWrite  (idRegWrite),
        .aluSrcImm (idAluSrcImm),
        .memRead   (idMemRead),
        .memWrite  (idMemWrite),
        .memToReg  (idMemToReg),
        .branch    (idBranch),
        .branchEq  (idBranchEq),
        .aluOp     (idAluOp),
        .signedOp  (idSignedOp)
    );

    regFile i_regFile (
        .iClk    (iClk),
        .iRst_n  (iRst_n),
        .rdIdA   (ifIdInst[25:21]),
        .rdIdB   (ifIdInst[20:16]),
        .rdDataA (idRsData),
        .rdDataB (idRtData),
        .wrId    (memWbWrId),
        .wrData  (memWbData),
        .wrEn    (memWbRegWrite)
    );

    // Bits that make a slot a bubble
    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            idExRegWrite <= 1'b0;
            idExMemRead  <= 1'b0;
            idExMemWrite <= 1'b0;
            idExBranch   <= 1'b0;
        end else if (flushIdEx) begin
            idExRegWrite <= 1'b0;
            idExMemRead  <= 1'b0;
            idExMemWrite <= 1'b0;
            idExBranch   <= 1'b0;
        end else begin
            idExRegWrite <= idRegWrite;
            idExMemRead  <= idMemRead;
            idExMemWrite <= idMemWrite;
            idExBranch   <= idBranch;
        end
    end

    always_ff @(posedge iClk) begin
        idExRegDst    <= idRegDst;
        idExAluSrcImm <= idAluSrcImm;
        idExMemToReg  <= idMemToReg;
        idExBranchEq  <= idBranchEq;
        idExAluOp     <= idAluOp;
        idExSignedOp  <= idSignedOp;
        idExRsData    <= idRsData;
        idExRtData    <= idRtData;
        idExPcPlus4   <= ifIdPcPlus4;
        idExRs        <= ifIdInst[25:21];
        idExRt        <= ifIdInst[20:16];
        idExRd        <= ifIdInst[15:11];
        idExImm       <= ifIdInst[15:0];
    end

    hazardUnit i_hazardUnit (
        .idRs          (ifIdInst[25:21]),
        .idRt          (ifIdInst[20:16]),
        .exRs          (idExRs),
        .exRt          (idExRt),
        .exMemWrId     (exMemWrId),
        .memWbWrId     (memWbWrId),
        .exMemRead     (idExMemRead),
        .exMemRegWrite (exMemRegWrite),
        .memWbRegWrite (memWbRegWrite),
        .branchTaken   (branchTaken),
        .fwdA          (fwdA),
        .fwdB          (fwdB),
        .stallFront    (stallFront),
        .flushIfId     (flushIfId),
        .flushIdEx     (flushIdEx)
    );

    // Operands after forwarding
    assign exRsVal = fwdMux(fwdA, idExRsData, exMemAluOut, memWbData);
    assign exRtVal = fwdMux(fwdB, idExRtData, exMemAluOut, memWbData);
    assign exImm   = {{(cpuPkg::dataW-cpuPkg::immW){idExImm[cpuPkg::immW-1]}}, idExImm};
    assign exAluB  = idExAluSrcImm ? exImm : exRtVal;
    assign exWrId  = idExRegDst ? idExRd : idExRt;

    alu i_alu (
        .a        (exRsVal),
        .b        (exAluB),
        .op       (idExAluOp),
        .signedOp (idExSignedOp),
        .result   (exAluOut),
        .zero     (exZero)
    );

    assign branchTaken  = idExBranch & (idExBranchEq ? exZero : ~exZero);
    assign branchTarget = idExPcPlus4 + {exImm[cpuPkg::dataW-3:0], 2'b00};

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            exMemRegWrite <= 1'b0;
            exMemMemRead  <= 1'b0;
            exMemMemWrite <= 1'b0;
            memWbRegWrite <= 1'b0;
        end else begin
            exMemRegWrite <= idExRegWrite;
            exMemMemRead  <= idExMemRead;
            exMemMemWrite <= idExMemWrite;
            memWbRegWrite <= exMemRegWrite;
        end
    end

    always_ff @(posedge iClk) begin
        exMemMemToReg  <= idExMemToReg;
        exMemAluOut    <= exAluOut;
        exMemStoreData <= exRtVal;
        exMemWrId      <= exWrId;
        // Load data or ALU result chosen in MEM
        memWbData      <= exMemMemToReg ? iMemRdData : exMemAluOut;
        memWbWrId      <= exMemWrId;
    end

    assign oMemAddr   = exMemAluOut;
    assign oMemWrData = exMemStoreData;
    assign oMemWrite  = exMemMemWrite;
    assign oMemRead   = exMemMemRead;

endmodule

`default_nettype wire

// File: verification/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

function automatic logic [31:0] encR(input cpuPkg::functE fn, input logic [4:0] rd,
                                     input logic [4:0] rs, input logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] encI(input cpuPkg::opcodeE op, input logic [4:0] rt,
                                     input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// Reference interpreter, runs up to the halt word and records every store
task automatic runModel();
    logic [31:0] regs [32];
    logic [31:0] inst, a, b, imm, ea, res;
    logic [4:0]  dst;
    logic        wr;
    int          pcIdx;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    pcIdx = 0;
    steps = 0;
    while (pcIdx < haltIdx && steps < 4 * romDepth) begin
        inst = prog[pcIdx];
        a    = regs[inst[25:21]];
        b    = regs[inst[20:16]];
        imm  = {{16{inst[15]}}, inst[15:0]};
        ea   = a + imm;
        dst  = inst[20:16];
        wr   = 1'b1;
        res  = '0;
        pcIdx++;
        steps++;
        case (inst[31:26])
            cpuPkg::rType: begin
                dst = inst[15:11];
                case (inst[5:0])
                    cpuPkg::fnAdd, cpuPkg::fnAddu: res = a + b;
                    cpuPkg::fnSub, cpuPkg::fnSubu: res = a - b;
                    cpuPkg::fnAnd: res = a & b;
                    cpuPkg::fnOr: res = a | b;
                    cpuPkg::fnXor: res = a ^ b;
                    cpuPkg::fnNor: res = ~(a | b);
                    cpuPkg::fnSlt: res = {31'd0, ($signed(a) < $signed(b))};
                    default: wr = 1'b0;
                endcase
            end
            cpuPkg::addi, cpuPkg::addiu: res = a + imm;
            cpuPkg::andi: res = a & imm;
            cpuPkg::ori: res = a | imm;
            cpuPkg::slti: res = {31'd0, ($signed(a) < $signed(imm))};
            cpuPkg::lui: res = {inst[15:0], 16'h0000};
            cpuPkg::lw: res = modelMem[ea[9:2]];
            cpuPkg::sw: begin
                wr = 1'b0;
                modelMem[ea[9:2]] = b;
                expAddr.push_back(ea);
                expData.push_back(b);
            end
            cpuPkg::beq, cpuPkg::bne: begin
                wr = 1'b0;
                // Offset counts words from the next instruction
                if ((a == b) == (inst[31:26] == cpuPkg::beq)) begin
                    pcIdx = pcIdx + $signed(imm);
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            regs[dst] = res;
        end
    end
endtask

`endif

// File: verification/coreTb.sv
`timescale 1ns/10ps
`default_nettype none

module coreTb;

    localparam int romDepth = 256;
    localparam int ramDepth = 256;
    localparam int storeSlots = 192;
    localparam int prefillBase = 200;
    localparam logic [31:0] seed = 32'd27;

    logic        iClk;
    logic        iRst_n;
    logic [31:0] instAddr, inst, romOff;
    logic [31:0] memAddr, memWrData, memRdData;
    logic        memWrite, memRead;

    logic [31:0] prog [romDepth];
    logic [31:0] dataRam [ramDepth];
    logic [31:0] modelMem [ramDepth];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] rngState;
    int          progLen;
    int          haltIdx;
    int          slot;
    int          errCount;
    int          storeCount;
    int          expTotal;
    logic        progReady;

    cpuPkg::functE rFuncts [9] = '{cpuPkg::fnAdd, cpuPkg::fnAddu, cpuPkg::fnSub,
        cpuPkg::fnSubu, cpuPkg::fnAnd, cpuPkg::fnOr, cpuPkg::fnXor, cpuPkg::fnNor,
        cpuPkg::fnSlt};
    cpuPkg::opcodeE iOps [6] = '{cpuPkg::addi, cpuPkg::addiu, cpuPkg::andi,
        cpuPkg::ori, cpuPkg::slti, cpuPkg::lui};

    `include "isaModel.svh"

    pipeCore i_pipeCore (
        .iClk       (iClk),
        .iRst_n     (iRst_n),
        .oInstAddr  (instAddr),
        .iInst      (inst),
        .oMemAddr   (memAddr),
        .oMemWrData (memWrData),
        .oMemWrite  (memWrite),
        .oMemRead   (memRead),
        .iMemRdData (memRdData)
    );

    // Instruction ROM and data RAM answer in the same cycle
    assign romOff    = instAddr - cpuPkg::resetPc;
    assign inst      = prog[romOff[9:2]];
    assign memRdData = dataRam[memAddr[9:2]];

    always @(posedge iClk) begin
        if (memWrite) begin
            dataRam[memAddr[9:2]] <= memWrData;
        end
    end

    initial begin
        iClk = 1'b0;
        forever begin
            #5 iClk = ~iClk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] drawRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Seeded registers r1..r8
    function automatic logic [4:0] randReg();
        return 5'(1 + drawRand() % 8);
    endfunction

    function automatic logic [31:0] fillWord(input int addr);
        return (32'(addr) * 32'h9E37_79B9) ^ {16'(addr), 16'hC3A5};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    // Next result slot addressed off r0
    task automatic storeReg(input logic [4:0] r);
        emit(encI(cpuPkg::sw, r, 5'd0, 16'(slot * 4)));
        slot = (slot + 1) % storeSlots;
    endtask

    task automatic emitAluOp(input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
        logic [31:0] r;
        int          k;
        r = drawRand();
        k = int'(r % 15);
        if (k < 9) begin
            emit(encR(rFuncts[k], rd, rs, rt));
        end else begin
            emit(encI(iOps[k - 9], rd, rs, r[15:0]));
        end
    endtask

    task automatic buildProgram();
        logic [31:0]    r;
        logic [4:0]     x, y, z;
        cpuPkg::opcodeE brOp;
        progLen = 0;
        slot = 0;
        for (int i = 0; i < romDepth; i++) begin
            prog[i] = '0;
        end
        for (int i = 0; i < ramDepth; i++) begin
            dataRam[i]  = fillWord(i);
            modelMem[i] = fillWord(i);
        end
        for (int i = 1; i <= 8; i++) begin
            r = drawRand();
            emit(encI(cpuPkg::lui, 5'(i), 5'd0, r[31:16]));
            emit(encI(cpuPkg::ori, 5'(i), 5'(i), r[15:0]));
        end
        // Random mix where r0 may also be a destination
        for (int i = 0; i < 36; i++) begin
            x = 5'(drawRand() % 9);
            y = 5'(drawRand() % 9);
            z = 5'(drawRand() % 9);
            emitAluOp(x, y, z);
            storeReg(x);
        end
        // Producer r9 and consumer r11 at distance d
        for (int d = 1; d <= 3; d++) begin
            for (int k = 0; k < 4; k++) begin
                x = randReg();
                y = randReg();
                emitAluOp(5'd9, x, y);
                for (int f = 1; f < d; f++) begin
                    emitAluOp(5'd10, y, x);
                end
                if (k[0]) begin
                    emit(encR(rFuncts[drawRand() % 9], 5'd11, x, 5'd9));
                end else begin
                    emit(encR(rFuncts[drawRand() % 9], 5'd11, 5'd9, y));
                end
                storeReg(5'd11);
            end
        end
        emit(encI(cpuPkg::addi, 5'd0, 5'd3, 16'h1234));
        storeReg(5'd0);
        emit(encR(cpuPkg::fnOr, 5'd0, 5'd4, 5'd5));
        storeReg(5'd0);
        // Load-use on a round trip and a preset word fed straight into a store
        for (int k = 0; k < 4; k++) begin
            x = randReg();
            emit(encI(cpuPkg::sw, x, 5'd0, 16'(slot * 4)));
            slot = (slot + 1) % storeSlots;
            emit(encI(cpuPkg::lw, 5'd12, 5'd0, prog[progLen - 1][15:0]));
            emit(encR(cpuPkg::fnAdd, 5'd13, 5'd12, x));
            storeReg(5'd13);
            emit(encI(cpuPkg::lw, 5'd14, 5'd0, 16'((prefillBase + k) * 4)));
            storeReg(5'd14);
        end
        // Branch over two shadow stores with equal or unequal operands
        for (int k = 0; k < 8; k++) begin
            x = randReg();
            y = k[0] ? x : 5'(x % 8 + 1);
            if (k[1]) begin
                brOp = cpuPkg::bne;
            end else begin
                brOp = cpuPkg::beq;
            end
            emit(encR(cpuPkg::fnAddu, 5'd15, x, 5'd0));
            emit(encI(brOp, y, 5'd15, 16'd2));
            storeReg(5'd15);
            storeReg(x);
            emitAluOp(5'd16, x, y);
            storeReg(5'd16);
        end
        // Three passes of a backward loop
        emit(encI(cpuPkg::addi, 5'd17, 5'd0, 16'd3));
        storeReg(5'd17);
        emit(encI(cpuPkg::addi, 5'd17, 5'd17, 16'hFFFF));
        emit(encI(cpuPkg::bne, 5'd0, 5'd17, 16'hFFFD));
        storeReg(5'd17);
        haltIdx = progLen;
        emit(encI(cpuPkg::beq, 5'd0, 5'd0, 16'hFFFF));
    endtask

    always @(negedge iClk) begin
        if (!iRst_n) begin
            assert (!memWrite && !memRead) else begin
                errCount++;
                $display("[ERROR] %0t: memory strobe active during reset", $time);
            end
        end
    end

    // Each DUT store against the next one of the interpreter
    always @(negedge iClk) begin
        if (iRst_n && memWrite) begin
            storeCount++;
            assert (expAddr.size() > 0) else begin
                errCount++;
                $display("[ERROR] %0t: extra store of %h to %h", $time, memWrData, memAddr);
            end
            if (expAddr.size() > 0) begin
                assert (memAddr == expAddr[0] && memWrData == expData[0]) else begin
                    errCount++;
                    $display("[ERROR] %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, storeCount, memWrData, memAddr, expData[0], expAddr[0]);
                end
                void'(expAddr.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    initial begin : watchdog
        wait (progReady);
        repeat (progLen * 4 + 100) @(posedge iClk);
        $display("Timeout: the program did not finish, %0d of %0d stores seen, %0d errors",
                 storeCount, expTotal, errCount);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        iRst_n = 1'b0;
        rngState = seed;
        errCount = 0;
        storeCount = 0;
        progReady = 1'b0;
        buildProgram();
        runModel();
        expTotal = expAddr.size();
        progReady = 1'b1;
        repeat (16) @(posedge iClk);
        iRst_n <= 1'b1;
        @(negedge iClk);
        assert (instAddr == cpuPkg::resetPc) else begin
            errCount++;
            $display("[ERROR] %0t: first fetch from %h, expected %h",
                     $time, instAddr, cpuPkg::resetPc);
        end
        while (storeCount < expTotal) begin
            @(negedge iClk);
        end
        // A few more cycles so that a late stray store is still caught
        repeat (8) @(negedge iClk);
        assert (storeCount == expTotal) else begin
            errCount++;
            $display("[ERROR] %0t: %0d stores seen, expected %0d", $time, storeCount, expTotal);
        end
        $display("Stores checked: %0d of %0d, errors: %0d", storeCount, expTotal, errCount);
        if (errCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+verification
design/cpuPkg.sv
design/instDecoder.sv
design/regFile.sv
design/alu.sv
design/hazardUnit.sv
design/pipeCore.sv
verification/coreTb.sv
